// ==== hdl/tap_controller.sv ====
// --------------------------------------------------
// JTAG TAP controller top with BYPASS, IDCODE, BUILD ID
// Chain controls are forwarded unregistered, no back-pressure
// --------------------------------------------------
`timescale 1ns/100ps

module tap_controller #(
    parameter tap_pkg::idcode_t BLD_ID_VALUE = 32'h0000_0001
) (
    input  logic                                tapc_tck,
    input  logic                                tapc_trst_n,
    input  logic                                tapc_tms_i,
    input  logic                                tapc_tdi_i,
    output logic                                tapc_tdo_o,
    output logic                                tapc_tdo_en_o,
    // Fuses
    input  tap_pkg::idcode_t                    fuse_idcode_i,
    // DMI and SCU scan chains
    output logic                                scu_chain_sel_o,
    output logic                                dmi_chain_sel_o,
    output logic [tap_pkg::TAP_CH_ID_WIDTH-1:0] chain_id_o,
    output logic                                chain_capture_o,
    output logic                                chain_shift_o,
    output logic                                chain_update_o,
    output logic                                chain_tdi_o,
    input  logic                                chain_tdo_i
);

    // FSM outputs
    tap_pkg::tap_state_e state;
    logic                sync_rst;
    logic                dr_capture;
    logic                dr_shift;
    logic                dr_update;
    logic                ir_shift;

    // Decode outputs
    logic ir_lsb;
    logic bypass_sel;
    logic idcode_sel;
    logic bld_id_sel;
    logic chain_sel;

    // DR serial outs
    logic bypass_tdo;
    logic idcode_tdo;
    logic bld_id_tdo;

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    tap_state_machine u_fsm (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .tms_i        (tapc_tms_i),
        .state_o      (state),
        .state_next_o (),
        .sync_rst_o   (sync_rst),
        .dr_capture_o (dr_capture),
        .dr_shift_o   (dr_shift),
        .dr_update_o  (dr_update),
        .ir_shift_o   (ir_shift)
    );

    tap_instruction_reg u_ir (
        .tapc_tck        (tapc_tck),
        .tapc_trst_n     (tapc_trst_n),
        .sync_rst_i      (sync_rst),
        .tdi_i           (tapc_tdi_i),
        .state_i         (state),
        .ir_lsb_o        (ir_lsb),
        .bypass_sel_o    (bypass_sel),
        .idcode_sel_o    (idcode_sel),
        .bld_id_sel_o    (bld_id_sel),
        .dmi_chain_sel_o (dmi_chain_sel_o),
        .scu_chain_sel_o (scu_chain_sel_o),
        .chain_id_o      (chain_id_o)
    );

    // --------------------------------------------------
    // Data registers
    // --------------------------------------------------
    // BYPASS, captures 0
    tap_data_shift_reg #(.payload_t(tap_pkg::bypass_t)) u_bypass_dr (
        .tapc_tck        (tapc_tck),
        .tapc_trst_n     (tapc_trst_n),
        .sync_rst_i      (sync_rst),
        .select_i        (bypass_sel),
        .capture_i       (dr_capture),
        .shift_i         (dr_shift),
        .tdi_i           (tapc_tdi_i),
        .capture_value_i (tap_pkg::bypass_t'(1'b0)),
        .tdo_o           (bypass_tdo)
    );

    // IDCODE from fuses
    tap_data_shift_reg #(.payload_t(tap_pkg::idcode_t)) u_idcode_dr (
        .tapc_tck        (tapc_tck),
        .tapc_trst_n     (tapc_trst_n),
        .sync_rst_i      (sync_rst),
        .select_i        (idcode_sel),
        .capture_i       (dr_capture),
        .shift_i         (dr_shift),
        .tdi_i           (tapc_tdi_i),
        .capture_value_i (fuse_idcode_i),
        .tdo_o           (idcode_tdo)
    );

    // BUILD ID, fixed at elaboration
    tap_data_shift_reg #(.payload_t(tap_pkg::idcode_t)) u_bld_id_dr (
        .tapc_tck        (tapc_tck),
        .tapc_trst_n     (tapc_trst_n),
        .sync_rst_i      (sync_rst),
        .select_i        (bld_id_sel),
        .capture_i       (dr_capture),
        .shift_i         (dr_shift),
        .tdi_i           (tapc_tdi_i),
        .capture_value_i (BLD_ID_VALUE),
        .tdo_o           (bld_id_tdo)
    );

    // --------------------------------------------------
    // TDO and external chains
    // --------------------------------------------------
    assign chain_sel = dmi_chain_sel_o | scu_chain_sel_o;

    tap_tdo_out u_tdo (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .sync_rst_i   (sync_rst),
        .dr_shift_i   (dr_shift),
        .ir_shift_i   (ir_shift),
        .ir_lsb_i     (ir_lsb),
        .bypass_tdo_i (bypass_tdo),
        .idcode_tdo_i (idcode_tdo),
        .bld_id_tdo_i (bld_id_tdo),
        .chain_tdo_i  (chain_tdo_i),
        .bypass_sel_i (bypass_sel),
        .idcode_sel_i (idcode_sel),
        .bld_id_sel_i (bld_id_sel),
        .chain_sel_i  (chain_sel),
        .tdo_o        (tapc_tdo_o),
        .tdo_en_o     (tapc_tdo_en_o)
    );

    // Chain side qualifies these with its own select
    assign chain_capture_o = dr_capture;
    assign chain_shift_o   = dr_shift;
    assign chain_update_o  = dr_update;
    assign chain_tdi_o     = tapc_tdi_i;

endmodule

// ==== hdl/tap_data_shift_reg.sv ====
// --------------------------------------------------
// Capture-and-shift DR, width taken from payload_t
// Serial out is the LSB, TDI enters at the MSB
// --------------------------------------------------
`timescale 1ns/100ps

module tap_data_shift_reg #(
    parameter type payload_t = tap_pkg::idcode_t
) (
    input  logic     tapc_tck,
    input  logic     tapc_trst_n,
    input  logic     sync_rst_i,
    input  logic     select_i,
    input  logic     capture_i,
    input  logic     shift_i,
    input  logic     tdi_i,
    input  payload_t capture_value_i,
    output logic     tdo_o
);

    localparam int W = $bits(payload_t);

    logic [W-1:0] shift_q;
    // One bit wider so a 1-bit payload shifts the same way
    logic [W:0]   shift_ext;

    assign shift_ext = {tdi_i, shift_q};

    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            shift_q <= '0;
        end else if (sync_rst_i) begin
            shift_q <= '0;
        end else if (select_i && capture_i) begin
            shift_q <= capture_value_i;
        end else if (select_i && shift_i) begin
            shift_q <= shift_ext[W:1];
        end
    end

    assign tdo_o = shift_q[0];

endmodule

// ==== hdl/tap_instruction_reg.sv ====
// --------------------------------------------------
// IR shift and hold registers with instruction decode
// Hold register updates on falling TCK, resets to IDCODE
// --------------------------------------------------
`timescale 1ns/100ps

module tap_instruction_reg (
    input  logic                                tapc_tck,
    input  logic                                tapc_trst_n,
    input  logic                                sync_rst_i,
    input  logic                                tdi_i,
    input  tap_pkg::tap_state_e                 state_i,
    output logic                                ir_lsb_o,
    output logic                                bypass_sel_o,
    output logic                                idcode_sel_o,
    output logic                                bld_id_sel_o,
    output logic                                dmi_chain_sel_o,
    output logic                                scu_chain_sel_o,
    output logic [tap_pkg::TAP_CH_ID_WIDTH-1:0] chain_id_o
);

    tap_pkg::tap_instr_t ir_shift_q;
    tap_pkg::tap_instr_t ir_hold_q;

    // --------------------------------------------------
    // Shift register, rising edge
    // --------------------------------------------------
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            ir_shift_q <= '0;
        end else if (sync_rst_i) begin
            ir_shift_q <= '0;
        end else if (state_i == tap_pkg::TAP_IR_CAPTURE) begin
            ir_shift_q <= tap_pkg::TAP_IR_CAPTURE_VALUE;
        end else if (state_i == tap_pkg::TAP_IR_SHIFT) begin
            // TDI in at the top, LSB goes out first
            ir_shift_q <= {tdi_i, ir_shift_q[tap_pkg::TAP_IR_WIDTH-1:1]};
        end
    end

    assign ir_lsb_o = ir_shift_q[0];

    // --------------------------------------------------
    // Hold register, falling edge
    // --------------------------------------------------
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            ir_hold_q <= tap_pkg::TAP_INSTR_IDCODE;
        end else if (sync_rst_i) begin
            ir_hold_q <= tap_pkg::TAP_INSTR_IDCODE;
        end else if (state_i == tap_pkg::TAP_IR_UPDATE) begin
            ir_hold_q <= ir_shift_q;
        end
    end

    // Decode, one-hot selects, unknown codes fall back to bypass
    always_comb begin
        bypass_sel_o    = 1'b0;
        idcode_sel_o    = 1'b0;
        bld_id_sel_o    = 1'b0;
        dmi_chain_sel_o = 1'b0;
        scu_chain_sel_o = 1'b0;
        chain_id_o      = '0;
        case (ir_hold_q)
            tap_pkg::TAP_INSTR_IDCODE:     idcode_sel_o = 1'b1;
            tap_pkg::TAP_INSTR_BLD_ID:     bld_id_sel_o = 1'b1;
            tap_pkg::TAP_INSTR_SCU_ACCESS: scu_chain_sel_o = 1'b1;
            tap_pkg::TAP_INSTR_DTMCS: begin
                dmi_chain_sel_o = 1'b1;
                chain_id_o      = 2'd1;
            end
            tap_pkg::TAP_INSTR_DMI_ACCESS: begin
                dmi_chain_sel_o = 1'b1;
                chain_id_o      = 2'd2;
            end
            default:                       bypass_sel_o = 1'b1;
        endcase
    end

endmodule

// ==== hdl/tap_pkg.sv ====
// --------------------------------------------------
// Shared TAP types, instruction codes and widths
// Instruction codes not listed below act as BYPASS
// --------------------------------------------------

package tap_pkg;

    // --------------------------------------------------
    // TAP FSM states
    // --------------------------------------------------
    typedef enum logic [3:0] {
        TAP_RESET,
        TAP_IDLE,
        TAP_DR_SELECT,
        TAP_DR_CAPTURE,
        TAP_DR_SHIFT,
        TAP_DR_EXIT1,
        TAP_DR_PAUSE,
        TAP_DR_EXIT2,
        TAP_DR_UPDATE,
        TAP_IR_SELECT,
        TAP_IR_CAPTURE,
        TAP_IR_SHIFT,
        TAP_IR_EXIT1,
        TAP_IR_PAUSE,
        TAP_IR_EXIT2,
        TAP_IR_UPDATE
    } tap_state_e;

    // --------------------------------------------------
    // Instruction register
    // --------------------------------------------------
    localparam int TAP_IR_WIDTH = 5;

    typedef logic [TAP_IR_WIDTH-1:0] tap_instr_t;

    localparam tap_instr_t TAP_INSTR_IDCODE     = 5'h01;
    localparam tap_instr_t TAP_INSTR_BLD_ID     = 5'h04;
    localparam tap_instr_t TAP_INSTR_SCU_ACCESS = 5'h09;
    localparam tap_instr_t TAP_INSTR_DTMCS      = 5'h10;
    localparam tap_instr_t TAP_INSTR_DMI_ACCESS = 5'h11;
    localparam tap_instr_t TAP_INSTR_BYPASS     = 5'h1F;

    // Fixed pattern seen at TDO during an IR scan
    localparam tap_instr_t TAP_IR_CAPTURE_VALUE = 5'b00001;

    // --------------------------------------------------
    // Scan chains and data register payloads
    // --------------------------------------------------
    // Chain id: 1 for DTMCS, 2 for DMI_ACCESS, else 0
    localparam int TAP_CH_ID_WIDTH = 2;

    // IDCODE and BUILD ID
    typedef logic [31:0] idcode_t;

    // BYPASS
    typedef logic [0:0] bypass_t;

endpackage

// ==== hdl/tap_state_machine.sv ====
// --------------------------------------------------
// IEEE 1149.1 TAP FSM, TMS sampled on rising TCK
// sync_rst_o follows Test-Logic-Reset half a cycle late
// --------------------------------------------------
`timescale 1ns/100ps

module tap_state_machine (
    input  logic                tapc_tck,
    input  logic                tapc_trst_n,
    input  logic                tms_i,
    output tap_pkg::tap_state_e state_o,
    output tap_pkg::tap_state_e state_next_o,
    output logic                sync_rst_o,
    output logic                dr_capture_o,
    output logic                dr_shift_o,
    output logic                dr_update_o,
    output logic                ir_shift_o
);

    tap_pkg::tap_state_e state_q;
    tap_pkg::tap_state_e state_next;

    // --------------------------------------------------
    // State register
    // --------------------------------------------------
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            state_q <= tap_pkg::TAP_RESET;
        end else begin
            state_q <= state_next;
        end
    end

    // Transition table, left branch on TMS=1
    always_comb begin
        case (state_q)
            tap_pkg::TAP_RESET:
                state_next = tms_i ? tap_pkg::TAP_RESET     : tap_pkg::TAP_IDLE;
            tap_pkg::TAP_IDLE:
                state_next = tms_i ? tap_pkg::TAP_DR_SELECT : tap_pkg::TAP_IDLE;
            tap_pkg::TAP_DR_SELECT:
                state_next = tms_i ? tap_pkg::TAP_IR_SELECT : tap_pkg::TAP_DR_CAPTURE;
            tap_pkg::TAP_DR_CAPTURE:
                state_next = tms_i ? tap_pkg::TAP_DR_EXIT1  : tap_pkg::TAP_DR_SHIFT;
            tap_pkg::TAP_DR_SHIFT:
                state_next = tms_i ? tap_pkg::TAP_DR_EXIT1  : tap_pkg::TAP_DR_SHIFT;
            tap_pkg::TAP_DR_EXIT1:
                state_next = tms_i ? tap_pkg::TAP_DR_UPDATE : tap_pkg::TAP_DR_PAUSE;
            tap_pkg::TAP_DR_PAUSE:
                state_next = tms_i ? tap_pkg::TAP_DR_EXIT2  : tap_pkg::TAP_DR_PAUSE;
            tap_pkg::TAP_DR_EXIT2:
                state_next = tms_i ? tap_pkg::TAP_DR_UPDATE : tap_pkg::TAP_DR_SHIFT;
            tap_pkg::TAP_DR_UPDATE:
                state_next = tms_i ? tap_pkg::TAP_DR_SELECT : tap_pkg::TAP_IDLE;
            tap_pkg::TAP_IR_SELECT:
                state_next = tms_i ? tap_pkg::TAP_RESET     : tap_pkg::TAP_IR_CAPTURE;
            tap_pkg::TAP_IR_CAPTURE:
                state_next = tms_i ? tap_pkg::TAP_IR_EXIT1  : tap_pkg::TAP_IR_SHIFT;
            tap_pkg::TAP_IR_SHIFT:
                state_next = tms_i ? tap_pkg::TAP_IR_EXIT1  : tap_pkg::TAP_IR_SHIFT;
            tap_pkg::TAP_IR_EXIT1:
                state_next = tms_i ? tap_pkg::TAP_IR_UPDATE : tap_pkg::TAP_IR_PAUSE;
            tap_pkg::TAP_IR_PAUSE:
                state_next = tms_i ? tap_pkg::TAP_IR_EXIT2  : tap_pkg::TAP_IR_PAUSE;
            tap_pkg::TAP_IR_EXIT2:
                state_next = tms_i ? tap_pkg::TAP_IR_UPDATE : tap_pkg::TAP_IR_SHIFT;
            tap_pkg::TAP_IR_UPDATE:
                state_next = tms_i ? tap_pkg::TAP_DR_SELECT : tap_pkg::TAP_IDLE;
            default:
                state_next = tap_pkg::TAP_RESET;
        endcase
    end

    // --------------------------------------------------
    // Internal reset, falling edge
    // --------------------------------------------------
    // Held high through TRST and for as long as the FSM sits in Test-Logic-Reset
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            sync_rst_o <= 1'b1;
        end else begin
            sync_rst_o <= (state_q == tap_pkg::TAP_RESET);
        end
    end

    // --------------------------------------------------
    // Registered control flags
    // --------------------------------------------------
    // Decoded from next state, so each flag matches its state cycle exactly
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            dr_capture_o <= 1'b0;
            dr_shift_o   <= 1'b0;
            dr_update_o  <= 1'b0;
            ir_shift_o   <= 1'b0;
        end else if (sync_rst_o) begin
            dr_capture_o <= 1'b0;
            dr_shift_o   <= 1'b0;
            dr_update_o  <= 1'b0;
            ir_shift_o   <= 1'b0;
        end else begin
            dr_capture_o <= (state_next == tap_pkg::TAP_DR_CAPTURE);
            dr_shift_o   <= (state_next == tap_pkg::TAP_DR_SHIFT);
            dr_update_o  <= (state_next == tap_pkg::TAP_DR_UPDATE);
            ir_shift_o   <= (state_next == tap_pkg::TAP_IR_SHIFT);
        end
    end

    assign state_o      = state_q;
    assign state_next_o = state_next;

endmodule

// ==== hdl/tap_tdo_out.sv ====
// --------------------------------------------------
// TDO source mux and falling-edge TDO/TDO_EN registers
// Selects are expected one-hot
// --------------------------------------------------
`timescale 1ns/100ps

module tap_tdo_out (
    input  logic tapc_tck,
    input  logic tapc_trst_n,
    input  logic sync_rst_i,
    input  logic dr_shift_i,
    input  logic ir_shift_i,
    input  logic ir_lsb_i,
    input  logic bypass_tdo_i,
    input  logic idcode_tdo_i,
    input  logic bld_id_tdo_i,
    input  logic chain_tdo_i,
    input  logic bypass_sel_i,
    input  logic idcode_sel_i,
    input  logic bld_id_sel_i,
    input  logic chain_sel_i,
    output logic tdo_o,
    output logic tdo_en_o
);

    logic dr_out;
    logic tdo_next;

    // AND-OR mux over the one-hot selects
    assign dr_out = (bypass_sel_i & bypass_tdo_i)
                  | (idcode_sel_i & idcode_tdo_i)
                  | (bld_id_sel_i & bld_id_tdo_i)
                  | (chain_sel_i  & chain_tdo_i);

    // DR shift wins, IR LSB otherwise, idle low
    assign tdo_next = dr_shift_i ? dr_out
                    : ir_shift_i ? ir_lsb_i
                    : 1'b0;

    // --------------------------------------------------
    // Output registers, falling edge
    // --------------------------------------------------
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            tdo_o    <= 1'b0;
            tdo_en_o <= 1'b0;
        end else if (sync_rst_i) begin
            tdo_o    <= 1'b0;
            tdo_en_o <= 1'b0;
        end else begin
            tdo_o    <= tdo_next;
            tdo_en_o <= dr_shift_i | ir_shift_i;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the TAP controller testbench with Verilator.
# Exit status is 0 only when the simulation reports a pass.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    -f tap_controller.f \
    --top-module tap_controller_tb \
    -o tap_controller_sim \
    && ./obj_dir/tap_controller_sim | tee /dev/stderr | grep -qx "Result: PASSED" \
    && exit 0 \
    || exit 1

// ==== tap_controller.f ====
hdl/tap_pkg.sv
hdl/tap_state_machine.sv
hdl/tap_instruction_reg.sv
hdl/tap_data_shift_reg.sv
hdl/tap_tdo_out.sv
hdl/tap_controller.sv
testbench/tap_controller_tb.sv

// ==== testbench/tap_controller_tb.sv ====
// --------------------------------------------------
// Testbench for the TAP controller, inputs driven on falling TCK
// TDO sampled on rising TCK, chain model is a 32-bit TDI delay
// --------------------------------------------------
`timescale 1ns/100ps

module tap_controller_tb;

    localparam int          HALF_PERIOD  = 20;
    localparam int          RESET_CYCLES = 16;
    localparam int          EN_TIMEOUT   = 8;
    localparam logic [31:0] SEED         = 32'h8698_c9b5;
    localparam logic [31:0] BLD_ID       = 32'h2020_0415;
    localparam logic [31:0] FUSE_IDCODE  = 32'h1DEB_C0DE;
    localparam logic [31:0] CHAIN_INIT   = 32'hC3A5_5A3C;

    // Kinds of expected DR response
    localparam int KIND_IDCODE = 0;
    localparam int KIND_BYPASS = 1;
    localparam int KIND_BLD_ID = 2;
    localparam int KIND_CHAIN  = 3;

    logic        tapc_tck;
    logic        tapc_trst_n;
    logic        tms;
    logic        tdi;
    logic        tdo;
    logic        tdo_en;
    logic        scu_sel;
    logic        dmi_sel;
    logic [1:0]  chain_id;
    logic        chain_capture;
    logic        chain_shift;
    logic        chain_update;
    logic        chain_tdi;
    logic        chain_tdo;
    logic [31:0] chain_q = CHAIN_INIT;

    // Scan table
    string       tbl_name[$];
    logic        tbl_has_ir[$];
    logic [4:0]  tbl_instr[$];
    logic        tbl_tlr[$];
    int          tbl_len[$];
    logic [31:0] tbl_tdi[$];
    logic [31:0] tbl_exp[$];
    logic        tbl_dmi[$];
    logic        tbl_scu[$];
    logic [1:0]  tbl_id[$];

    logic [31:0] rng;
    logic [31:0] chain_expect;
    int          errors;
    int          checks;

    tap_controller #(
        .BLD_ID_VALUE (BLD_ID)
    ) UUT (
        .tapc_tck        (tapc_tck),
        .tapc_trst_n     (tapc_trst_n),
        .tapc_tms_i      (tms),
        .tapc_tdi_i      (tdi),
        .tapc_tdo_o      (tdo),
        .tapc_tdo_en_o   (tdo_en),
        .fuse_idcode_i   (FUSE_IDCODE),
        .scu_chain_sel_o (scu_sel),
        .dmi_chain_sel_o (dmi_sel),
        .chain_id_o      (chain_id),
        .chain_capture_o (chain_capture),
        .chain_shift_o   (chain_shift),
        .chain_update_o  (chain_update),
        .chain_tdi_o     (chain_tdi),
        .chain_tdo_i     (chain_tdo)
    );

    always #(HALF_PERIOD) tapc_tck = ~tapc_tck;

    // --------------------------------------------------
    // External chain model
    // --------------------------------------------------
    // Shifts on falling TCK, so chain TDO changes only there
    always @(negedge tapc_tck) begin
        if (chain_shift && (dmi_sel || scu_sel)) begin
            chain_q <= {chain_tdi, chain_q[31:1]};
        end
    end

    assign chain_tdo = chain_q[0];

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        lcg_next = state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic add_entry(input string name, input logic has_ir, input logic [4:0] instr,
                             input logic tlr, input int kind, input logic dmi,
                             input logic scu, input logic [1:0] id);
        logic [31:0] data;
        logic [31:0] expect_word;
        rng  = lcg_next(rng);
        data = rng;
        case (kind)
            KIND_IDCODE: expect_word = FUSE_IDCODE;
            // Captured 0, then TDI one bit late
            KIND_BYPASS: expect_word = {data[30:0], 1'b0};
            KIND_BLD_ID: expect_word = BLD_ID;
            default: begin
                expect_word  = chain_expect;
                // Model keeps TDI one bit late, TDI low before the scan
                chain_expect = {data[30:0], 1'b0};
            end
        endcase
        tbl_name.push_back(name);
        tbl_has_ir.push_back(has_ir);
        tbl_instr.push_back(instr);
        tbl_tlr.push_back(tlr);
        tbl_len.push_back(32);
        tbl_tdi.push_back(data);
        tbl_exp.push_back(expect_word);
        tbl_dmi.push_back(dmi);
        tbl_scu.push_back(scu);
        tbl_id.push_back(id);
    endtask

    task automatic build_table();
        rng          = SEED;
        chain_expect = CHAIN_INIT;
        add_entry("idcode_after_reset", 1'b0, 5'h01, 1'b0, KIND_IDCODE, 1'b0, 1'b0, 2'd0);
        add_entry("bypass",             1'b1, 5'h1F, 1'b0, KIND_BYPASS, 1'b0, 1'b0, 2'd0);
        add_entry("unlisted_0a",        1'b1, 5'h0A, 1'b0, KIND_BYPASS, 1'b0, 1'b0, 2'd0);
        add_entry("bld_id",             1'b1, 5'h04, 1'b0, KIND_BLD_ID, 1'b0, 1'b0, 2'd0);
        add_entry("dtmcs",              1'b1, 5'h10, 1'b0, KIND_CHAIN,  1'b1, 1'b0, 2'd1);
        add_entry("dmi_access",         1'b1, 5'h11, 1'b0, KIND_CHAIN,  1'b1, 1'b0, 2'd2);
        add_entry("scu_access",         1'b1, 5'h09, 1'b0, KIND_CHAIN,  1'b0, 1'b1, 2'd0);
        add_entry("bypass_again",       1'b1, 5'h1F, 1'b0, KIND_BYPASS, 1'b0, 1'b0, 2'd0);
        add_entry("tlr_idcode",         1'b0, 5'h01, 1'b1, KIND_IDCODE, 1'b0, 1'b0, 2'd0);
    endtask

    // One TCK cycle with the given TMS, TDI low
    task automatic step(input logic tms_value);
        @(negedge tapc_tck);
        tms <= tms_value;
        tdi <= 1'b0;
        @(posedge tapc_tck);
    endtask

    task automatic wait_tdo_en(input string name);
        int cnt;
        cnt = 0;
        while (!tdo_en && cnt < EN_TIMEOUT) begin
            @(posedge tapc_tck);
            cnt++;
        end
        if (!tdo_en) begin
            errors++;
            $display("%s: timed out waiting for TDO_EN to rise", name);
        end
    endtask

    // --------------------------------------------------
    // IR scan from Run-Test/Idle back to Run-Test/Idle
    // --------------------------------------------------
    task automatic ir_scan(input string name, input logic [4:0] instr);
        logic [4:0] cap;
        logic [4:0] data;
        cap  = 5'b00001;
        data = instr;
        step(1'b1);
        step(1'b1);
        step(1'b0);
        step(1'b0);
        for (int k = 0; k < 5; k++) begin
            @(negedge tapc_tck);
            tms <= (k == 4);
            tdi <= data[0];
            data = data >> 1;
            @(posedge tapc_tck);
            if (k == 0) begin
                wait_tdo_en({name, "_ir"});
            end
            check_value({name, "_ir_tdo_en"}, 32'd1, 32'(tdo_en));
            check_value({name, "_ir_tdo"}, 32'(cap[0]), 32'(tdo));
            cap = cap >> 1;
        end
        // Update-IR, enable must have dropped after five bits
        step(1'b1);
        check_value({name, "_ir_tdo_en_end"}, 32'd0, 32'(tdo_en));
        step(1'b0);
    endtask

    // --------------------------------------------------
    // DR scan of one table entry
    // --------------------------------------------------
    task automatic dr_scan(input int i);
        logic [31:0] data;
        logic [31:0] expect_word;
        string       name;
        name        = tbl_name[i];
        data        = tbl_tdi[i];
        expect_word = tbl_exp[i];
        step(1'b1);
        step(1'b0);
        @(negedge tapc_tck);
        check_value({name, "_capture"}, 32'd1, 32'(chain_capture));
        tms <= 1'b0;
        tdi <= 1'b0;
        @(posedge tapc_tck);
        for (int k = 0; k < tbl_len[i]; k++) begin
            @(negedge tapc_tck);
            check_value({name, "_shift"}, 32'd1, 32'(chain_shift));
            tms <= (k == tbl_len[i] - 1);
            tdi <= data[0];
            @(posedge tapc_tck);
            if (k == 0) begin
                wait_tdo_en(name);
            end
            check_value({name, "_tdo_en"}, 32'd1, 32'(tdo_en));
            check_value({name, "_chain_tdi"}, 32'(data[0]), 32'(chain_tdi));
            check_value({name, "_tdo"}, 32'(expect_word[0]), 32'(tdo));
            data        = data >> 1;
            expect_word = expect_word >> 1;
        end
        // Entering Update-DR, enable dropped right after the last bit
        step(1'b1);
        check_value({name, "_tdo_en_end"}, 32'd0, 32'(tdo_en));
        @(negedge tapc_tck);
        check_value({name, "_update"}, 32'd1, 32'(chain_update));
        tms <= 1'b0;
        @(posedge tapc_tck);
    endtask

    initial begin
        tapc_tck    = 1'b0;
        tapc_trst_n <= 1'b0;
        tms         <= 1'b1;
        tdi         <= 1'b0;
        errors      = 0;
        checks      = 0;
        build_table();

        repeat (RESET_CYCLES) @(posedge tapc_tck);
        @(negedge tapc_tck);
        tapc_trst_n <= 1'b1;
        @(negedge tapc_tck);
        check_value("reset_capture", 32'd0, 32'(chain_capture));
        check_value("reset_shift", 32'd0, 32'(chain_shift));
        check_value("reset_update", 32'd0, 32'(chain_update));
        @(posedge tapc_tck);
        check_value("reset_tdo_en", 32'd0, 32'(tdo_en));
        step(1'b0);

        for (int i = 0; i < tbl_name.size(); i++) begin
            if (tbl_tlr[i]) begin
                // Five TMS high cycles reach Test-Logic-Reset
                repeat (5) step(1'b1);
                step(1'b0);
            end
            if (tbl_has_ir[i]) begin
                ir_scan(tbl_name[i], tbl_instr[i]);
            end
            @(posedge tapc_tck);
            check_value({tbl_name[i], "_dmi_sel"}, 32'(tbl_dmi[i]), 32'(dmi_sel));
            check_value({tbl_name[i], "_scu_sel"}, 32'(tbl_scu[i]), 32'(scu_sel));
            check_value({tbl_name[i], "_chain_id"}, 32'(tbl_id[i]), 32'(chain_id));
            dr_scan(i);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
